// File: source/i2c_bridge_pkg.sv
`default_nettype none

package i2c_bridge_pkg;

	localparam logic [5:0] reg_ofs_ctrl = 6'h00;
	localparam logic [5:0] reg_ofs_addr = 6'h04;
	localparam logic [5:0] reg_ofs_tx   = 6'h08;
	localparam logic [5:0] reg_ofs_rx   = 6'h0c;

	localparam int count_w = 9; // fits status layout, depth <= 256

	typedef struct packed {
		logic        stb;
		logic        we;
		logic [5:0]  adr;
		logic [31:0] wdat;
	} bus_req_t;

	typedef struct packed {
		logic wstop; // write ended with stop
		logic rstop; // read ended with stop
		logic rerr;  // read address refused
	} i2c_event_t;

	typedef struct packed {
		logic [5:0]  rsvd_hi;
		logic        unmask_rx;
		logic        mask_rx;
		logic        soft_rst;
		logic        tx_rst;
		logic        rx_rst;
		logic        clr_rerr;
		logic        clr_rstop;
		logic        clr_wstop;
		logic [17:0] rsvd_lo;
	} ctrl_cmd_t;

	typedef struct packed {
		logic [6:0]         zero;
		logic               rx_mask;
		logic               soft_rst; // pulses, read as zero
		logic               tx_rst;
		logic               rx_rst;
		logic               rerr;
		logic               rstop;
		logic               wstop;
		logic [count_w-1:0] tx_count;
		logic [count_w-1:0] rx_count;
	} ctrl_stat_t;

	typedef union packed {
		ctrl_cmd_t  cmd;  // write view
		ctrl_stat_t stat; // read view
	} ctrl_word_u;

endpackage

`default_nettype wire

// File: source/i2c_fifo.sv
`default_nettype none

module i2c_fifo #(
	parameter int FIFO_DEPTH = 256
) (
	input  logic                               CLK_I,
	input  logic                               RST_I,
	input  logic                               clr,
	input  logic                               push,
	input  logic [31:0]                        wdata,
	input  logic                               pop,
	output logic [31:0]                        rdata,
	output logic [i2c_bridge_pkg::count_w-1:0] count
);

	localparam int ptr_w = $clog2(FIFO_DEPTH);
	localparam int cnt_w = i2c_bridge_pkg::count_w;

	logic [31:0]      mem [FIFO_DEPTH];
	logic [ptr_w-1:0] wptr;
	logic [ptr_w-1:0] rptr;
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign full    = (count == cnt_w'(FIFO_DEPTH));
	assign do_push = push & ~full;
	assign do_pop  = pop & (count != '0); // empty pop ignored
	assign rdata   = mem[rptr]; // head visible without a request

	always_ff @(posedge CLK_I) begin
		if (do_push)
			mem[wptr] <= wdata;
	end

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else if (clr) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wptr <= wptr + 1'b1; // wraps, depth is a power of two
			if (do_pop)
				rptr <= rptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// packet flow control upstream should keep writers off a full FIFO
	a_no_push_full: assert property (@(posedge CLK_I) disable iff (RST_I)
		!(push && full && !clr));

endmodule

`default_nettype wire

// File: source/i2c_phy.sv
`default_nettype none

module i2c_phy (
	input  logic                       CLK_I,
	input  logic                       RST_I,
	input  logic                       soft_rst,
	input  logic                       scl_pin,
	inout  wire                        sda_pin,
	input  logic [6:0]                 dev_addr,
	input  logic                       rx_room,
	input  logic                       tx_ready,
	output logic                       rx_push,
	output logic [31:0]                rx_word,
	output logic                       tx_pop,
	input  logic [31:0]                tx_word,
	output i2c_bridge_pkg::i2c_event_t evt
);

	localparam logic [3:0] st_idle     = 4'd0;
	localparam logic [3:0] st_addr     = 4'd1;
	localparam logic [3:0] st_addr_dec = 4'd2;
	localparam logic [3:0] st_ack_w    = 4'd3;
	localparam logic [3:0] st_wr_data  = 4'd4;
	localparam logic [3:0] st_wr_dec   = 4'd5;
	localparam logic [3:0] st_ack_r    = 4'd6;
	localparam logic [3:0] st_rd_data  = 4'd7;
	localparam logic [3:0] st_rd_ack   = 4'd8;

	logic [2:0]  scl_q;
	logic [2:0]  sda_q;
	logic        scl_s;
	logic        scl_p;
	logic        sda_s;
	logic        sda_p;
	logic        scl_rise;
	logic        scl_fall;
	logic        start;
	logic        stop;
	logic [3:0]  state;
	logic [2:0]  bit_cnt;
	logic [1:0]  byte_cnt;
	logic [7:0]  sh;       // incoming byte
	logic [31:0] tx_sh;    // outgoing word, msb first
	logic        sda_low;
	logic        xfer_wr;
	logic        xfer_rd;

	assign sda_pin = sda_low ? 1'b0 : 1'bz; // open drain

	// two flops of sync, third stage for edges
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			scl_q <= 3'b111;
			sda_q <= 3'b111;
		end else begin
			scl_q <= {scl_q[1:0], scl_pin};
			sda_q <= {sda_q[1:0], sda_pin};
		end
	end

	assign scl_s    = scl_q[1];
	assign scl_p    = scl_q[2];
	assign sda_s    = sda_q[1];
	assign sda_p    = sda_q[2];
	assign scl_rise = scl_s & ~scl_p;
	assign scl_fall = ~scl_s & scl_p;
	assign start    = scl_s & scl_p & sda_p & ~sda_s;
	assign stop     = scl_s & scl_p & ~sda_p & sda_s;

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			state    <= st_idle;
			bit_cnt  <= '0;
			byte_cnt <= '0;
			sda_low  <= 1'b0;
			xfer_wr  <= 1'b0;
			xfer_rd  <= 1'b0;
			rx_push  <= 1'b0;
			tx_pop   <= 1'b0;
			evt      <= '0;
		end else if (soft_rst) begin
			state    <= st_idle;
			bit_cnt  <= '0;
			byte_cnt <= '0;
			sda_low  <= 1'b0;
			xfer_wr  <= 1'b0;
			xfer_rd  <= 1'b0;
			rx_push  <= 1'b0;
			tx_pop   <= 1'b0;
			evt      <= '0;
		end else begin
			rx_push <= 1'b0;
			tx_pop  <= 1'b0;
			evt     <= '0;
			if (start) begin // also repeated start, partial word dropped
				state    <= st_addr;
				bit_cnt  <= '0;
				byte_cnt <= '0;
				sda_low  <= 1'b0;
				xfer_wr  <= 1'b0;
				xfer_rd  <= 1'b0;
			end else if (stop) begin
				state     <= st_idle;
				sda_low   <= 1'b0;
				evt.wstop <= xfer_wr;
				evt.rstop <= xfer_rd;
				xfer_wr   <= 1'b0;
				xfer_rd   <= 1'b0;
			end else begin
				case (state)
					st_addr, st_wr_data: if (scl_rise) begin
						sh      <= {sh[6:0], sda_s};
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= (state == st_addr) ? st_addr_dec : st_wr_dec;
					end
					st_addr_dec: if (scl_fall) begin
						byte_cnt <= '0;
						if (sh[7:1] != dev_addr) begin
							state <= st_idle; // not us
						end else if (!sh[0]) begin
							if (rx_room) begin
								sda_low <= 1'b1;
								xfer_wr <= 1'b1;
								state   <= st_ack_w;
							end else begin
								state <= st_idle; // no room for a packet
							end
						end else if (tx_ready) begin
							sda_low <= 1'b1;
							xfer_rd <= 1'b1;
							tx_sh   <= tx_word;
							tx_pop  <= 1'b1;
							state   <= st_ack_r;
						end else begin
							evt.rerr <= 1'b1;
							state    <= st_idle;
						end
					end
					st_ack_w: if (scl_fall) begin
						sda_low <= 1'b0; // end of ack bit
						bit_cnt <= '0;
						state   <= st_wr_data;
					end
					st_wr_dec: if (scl_fall) begin
						sda_low  <= 1'b1;
						rx_word  <= {rx_word[23:0], sh}; // first byte ends up in 31:24
						rx_push  <= (byte_cnt == 2'd3);
						byte_cnt <= byte_cnt + 1'b1;
						state    <= st_ack_w;
					end
					st_ack_r: if (scl_fall) begin
						sda_low <= ~tx_sh[31]; // bit 7 of next byte
						tx_sh   <= {tx_sh[30:0], 1'b0};
						bit_cnt <= '0;
						state   <= st_rd_data;
					end
					st_rd_data: if (scl_fall) begin
						if (bit_cnt == 3'd7) begin
							sda_low <= 1'b0; // master acks
							state   <= st_rd_ack;
						end else begin
							sda_low <= ~tx_sh[31];
							tx_sh   <= {tx_sh[30:0], 1'b0};
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
					st_rd_ack: if (scl_rise) begin
						if (sda_s) begin
							state <= st_idle; // nack ends the read
						end else begin
							if (byte_cnt == 2'd3) begin
								tx_sh  <= tx_word;
								tx_pop <= 1'b1;
							end
							byte_cnt <= byte_cnt + 1'b1;
							state    <= st_ack_r;
						end
					end
					default: ;
				endcase
			end
		end
	end

	a_push_pop_excl: assert property (@(posedge CLK_I) disable iff (RST_I)
		!(rx_push && tx_pop));
	a_idle_released: assert property (@(posedge CLK_I) disable iff (RST_I)
		(state == st_idle) |-> !sda_low);

endmodule

`default_nettype wire

// File: source/i2c_regs.sv
`default_nettype none

module i2c_regs #(
	parameter int FIFO_DEPTH = 256,
	parameter int PKG_LEN    = 10
) (
	input  logic                               CLK_I,
	input  logic                               RST_I,
	input  i2c_bridge_pkg::bus_req_t           bus_req,
	output logic                               bus_ack,
	output logic [31:0]                        bus_rdata,
	input  i2c_bridge_pkg::i2c_event_t         evt,
	output logic [6:0]                         dev_addr,
	output logic                               rx_room,
	output logic                               tx_ready,
	input  logic [i2c_bridge_pkg::count_w-1:0] tx_count,
	input  logic [i2c_bridge_pkg::count_w-1:0] rx_count,
	output logic                               tx_push,
	output logic [31:0]                        tx_wdata,
	output logic                               rx_pop,
	input  logic [31:0]                        rx_head,
	output logic                               soft_rst,
	output logic                               tx_clr,
	output logic                               rx_clr,
	output logic                               int_i2c
);

	logic                       accept;
	logic                       wr_ctrl;
	logic                       wr_addr;
	logic                       wr_tx;
	logic                       rd_rx;
	logic                       wstop;
	logic                       rstop;
	logic                       rerr;
	logic                       rx_mask;
	i2c_bridge_pkg::ctrl_word_u cmd_word;
	i2c_bridge_pkg::ctrl_word_u stat_word;

	assign accept  = bus_req.stb & ~bus_ack;
	assign wr_ctrl = accept & bus_req.we & (bus_req.adr == i2c_bridge_pkg::reg_ofs_ctrl);
	assign wr_addr = accept & bus_req.we & (bus_req.adr == i2c_bridge_pkg::reg_ofs_addr);
	assign wr_tx   = accept & bus_req.we & (bus_req.adr == i2c_bridge_pkg::reg_ofs_tx);
	assign rd_rx   = accept & ~bus_req.we & (bus_req.adr == i2c_bridge_pkg::reg_ofs_rx);
	assign rx_pop  = rd_rx & (rx_count != '0); // empty read pops nothing

	assign cmd_word = bus_req.wdat;

	// packet level flow control
	assign rx_room  = (int'(rx_count) + PKG_LEN) <= FIFO_DEPTH;
	assign tx_ready = int'(tx_count) >= PKG_LEN;
	assign int_i2c  = (rx_count != '0) & ~rx_mask;

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			bus_ack <= 1'b0;
		else
			bus_ack <= accept; // one cycle ack
	end

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			soft_rst <= 1'b0;
			tx_clr   <= 1'b0;
			rx_clr   <= 1'b0;
		end else begin
			soft_rst <= wr_ctrl & cmd_word.cmd.soft_rst;
			tx_clr   <= wr_ctrl & (cmd_word.cmd.tx_rst | cmd_word.cmd.soft_rst);
			rx_clr   <= wr_ctrl & (cmd_word.cmd.rx_rst | cmd_word.cmd.soft_rst);
		end
	end

	// sticky status, bus clear beats a new event
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			wstop   <= 1'b0;
			rstop   <= 1'b0;
			rerr    <= 1'b0;
			rx_mask <= 1'b1;
		end else if (soft_rst) begin
			wstop   <= 1'b0;
			rstop   <= 1'b0;
			rerr    <= 1'b0;
			rx_mask <= 1'b1;
		end else begin
			if (wr_ctrl && cmd_word.cmd.clr_wstop)
				wstop <= 1'b0;
			else if (evt.wstop)
				wstop <= 1'b1;
			if (wr_ctrl && cmd_word.cmd.clr_rstop)
				rstop <= 1'b0;
			else if (evt.rstop)
				rstop <= 1'b1;
			if (wr_ctrl && cmd_word.cmd.clr_rerr)
				rerr <= 1'b0;
			else if (evt.rerr)
				rerr <= 1'b1;
			if (wr_ctrl && cmd_word.cmd.mask_rx)
				rx_mask <= 1'b1; // mask wins
			else if (wr_ctrl && cmd_word.cmd.unmask_rx)
				rx_mask <= 1'b0;
		end
	end

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			dev_addr <= '0;
			tx_push  <= 1'b0;
		end else begin
			if (wr_addr)
				dev_addr <= bus_req.wdat[6:0];
			tx_push <= wr_tx; // push lands a cycle later
		end
	end

	always_ff @(posedge CLK_I) begin
		if (wr_tx)
			tx_wdata <= bus_req.wdat;
	end

	always_comb begin
		stat_word               = '0;
		stat_word.stat.rx_mask  = rx_mask;
		stat_word.stat.rerr     = rerr;
		stat_word.stat.rstop    = rstop;
		stat_word.stat.wstop    = wstop;
		stat_word.stat.tx_count = tx_count;
		stat_word.stat.rx_count = rx_count;
	end

	always_ff @(posedge CLK_I) begin
		if (accept && !bus_req.we) begin
			case (bus_req.adr)
				i2c_bridge_pkg::reg_ofs_ctrl: bus_rdata <= stat_word;
				i2c_bridge_pkg::reg_ofs_addr: bus_rdata <= {25'b0, dev_addr};
				i2c_bridge_pkg::reg_ofs_rx:   bus_rdata <= rx_head; // stale head if empty
				default:                      bus_rdata <= 32'hdeaddead;
			endcase
		end
	end

	a_ack_single: assert property (@(posedge CLK_I) disable iff (RST_I)
		bus_ack |=> !bus_ack);
	a_pop_read: assert property (@(posedge CLK_I) disable iff (RST_I)
		rx_pop |=> bus_ack && bus_rdata == $past(rx_head));

endmodule

`default_nettype wire

// File: source/i2c_bridge.sv
`default_nettype none

module i2c_bridge #(
	parameter int FIFO_DEPTH = 256,
	parameter int PKG_LEN    = 10
) (
	input  logic                     CLK_I,
	input  logic                     RST_I,
	input  i2c_bridge_pkg::bus_req_t bus_req,
	output logic                     bus_ack,
	output logic [31:0]              bus_rdata,
	input  logic                     scl_pin,
	inout  wire                      sda_pin,
	output logic                     int_i2c
);

	localparam int cnt_w = i2c_bridge_pkg::count_w;

	i2c_bridge_pkg::i2c_event_t evt;
	logic [6:0]       dev_addr;
	logic             rx_room;
	logic             tx_ready;
	logic [cnt_w-1:0] tx_count;
	logic [cnt_w-1:0] rx_count;
	logic             tx_push;
	logic [31:0]      tx_wdata;
	logic             tx_pop;
	logic [31:0]      tx_word;
	logic             rx_push;
	logic [31:0]      rx_word;
	logic             rx_pop;
	logic [31:0]      rx_head;
	logic             soft_rst;
	logic             tx_clr;
	logic             rx_clr;

	i2c_regs #(.FIFO_DEPTH(FIFO_DEPTH), .PKG_LEN(PKG_LEN)) regs (
		.CLK_I(CLK_I), .RST_I(RST_I), .bus_req(bus_req), .bus_ack(bus_ack),
		.bus_rdata(bus_rdata), .evt(evt), .dev_addr(dev_addr), .rx_room(rx_room),
		.tx_ready(tx_ready), .tx_count(tx_count), .rx_count(rx_count),
		.tx_push(tx_push), .tx_wdata(tx_wdata), .rx_pop(rx_pop), .rx_head(rx_head),
		.soft_rst(soft_rst), .tx_clr(tx_clr), .rx_clr(rx_clr), .int_i2c(int_i2c));

	i2c_phy phy (
		.CLK_I(CLK_I), .RST_I(RST_I), .soft_rst(soft_rst), .scl_pin(scl_pin),
		.sda_pin(sda_pin), .dev_addr(dev_addr), .rx_room(rx_room), .tx_ready(tx_ready),
		.rx_push(rx_push), .rx_word(rx_word), .tx_pop(tx_pop), .tx_word(tx_word),
		.evt(evt));

	i2c_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
		.CLK_I(CLK_I), .RST_I(RST_I), .clr(tx_clr), .push(tx_push), .wdata(tx_wdata),
		.pop(tx_pop), .rdata(tx_word), .count(tx_count));

	i2c_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
		.CLK_I(CLK_I), .RST_I(RST_I), .clr(rx_clr), .push(rx_push), .wdata(rx_word),
		.pop(rx_pop), .rdata(rx_head), .count(rx_count));

endmodule

`default_nettype wire

// File: verification/i2c_bridge_tb.sv
`default_nettype none

module i2c_bridge_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int fifo_depth    = 16;
	localparam int pkg_len       = 2;
	localparam int clk_period    = 100;
	localparam int clks_per_bit  = 16;
	localparam int n_tests       = 6;
	localparam int max_bytes     = 80; // per test, address bytes included
	localparam int watchdog_clks = 2 * n_tests * max_bytes * 9 * clks_per_bit;

	localparam logic [6:0] own_addr   = 7'h5a;
	localparam logic [6:0] other_addr = 7'h21;

	localparam logic [31:0] cmd_unmask_rx = 32'h0200_0000;
	localparam logic [31:0] cmd_mask_rx   = 32'h0100_0000;
	localparam logic [31:0] cmd_soft_rst  = 32'h0080_0000;
	localparam logic [31:0] cmd_tx_rst    = 32'h0040_0000;
	localparam logic [31:0] cmd_rx_rst    = 32'h0020_0000;
	localparam logic [31:0] cmd_clr_rerr  = 32'h0010_0000;
	localparam logic [31:0] cmd_clr_wstop = 32'h0004_0000;

	logic                     CLK_I = 1'b0;
	logic                     RST_I;
	i2c_bridge_pkg::bus_req_t bus_req;
	logic                     bus_ack;
	logic [31:0]              bus_rdata;
	logic                     scl_pin;
	wire                      sda_pin;
	logic                     sda_drv_low;
	logic                     int_i2c;

	logic [31:0] tx_q[$]; // model of the transmit FIFO
	logic [31:0] rx_q[$]; // model of the receive FIFO
	logic [6:0]  m_dev_addr;
	logic        m_wstop;
	logic        m_rstop;
	logic        m_rerr;
	logic        m_rx_mask;

	int    errors;
	int    checks;
	int    tests;
	int    failed_tests;
	int    test_err_base;
	string test_name;

	assign sda_pin = sda_drv_low ? 1'b0 : 1'bz; // open drain master
	pullup sda_pullup (sda_pin);

	always #(clk_period / 2) CLK_I = ~CLK_I;

	i2c_bridge #(.FIFO_DEPTH(fifo_depth), .PKG_LEN(pkg_len)) UUT (
		.CLK_I(CLK_I), .RST_I(RST_I), .bus_req(bus_req), .bus_ack(bus_ack),
		.bus_rdata(bus_rdata), .scl_pin(scl_pin), .sda_pin(sda_pin), .int_i2c(int_i2c));

	function automatic logic [31:0] exp_status();
		i2c_bridge_pkg::ctrl_stat_t s;
		s          = '0; // pulse bits read as zero
		s.rx_mask  = m_rx_mask;
		s.rerr     = m_rerr;
		s.rstop    = m_rstop;
		s.wstop    = m_wstop;
		s.tx_count = 9'(tx_q.size());
		s.rx_count = 9'(rx_q.size());
		return s;
	endfunction

	function automatic logic exp_int();
		return (rx_q.size() != 0) && !m_rx_mask;
	endfunction

	// packet flow rules decide the address ack
	function automatic logic exp_addr_ack(input logic [6:0] addr, input logic rd);
		if (addr != m_dev_addr)
			return 1'b0;
		if (rd)
			return tx_q.size() >= pkg_len;
		return rx_q.size() + pkg_len <= fifo_depth;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic wait_clks(input int n);
		repeat (n) @(negedge CLK_I);
	endtask

	task automatic bus_access(input logic we, input logic [5:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		int waited;
		waited = 0;
		@(negedge CLK_I);
		bus_req.stb  = 1'b1;
		bus_req.we   = we;
		bus_req.adr  = adr;
		bus_req.wdat = wdat;
		@(negedge CLK_I);
		while (!bus_ack && waited < 20) begin
			@(negedge CLK_I);
			waited++;
		end
		rdat    = bus_rdata;
		bus_req = '0;
		if (!bus_ack) begin
			errors++;
			$display("bus access to offset %h was never acknowledged", adr);
		end
	endtask

	task automatic check_status(input string name);
		logic [31:0] d;
		bus_access(1'b0, i2c_bridge_pkg::reg_ofs_ctrl, 32'h0, d);
		check(name, exp_status(), d);
	endtask

	task automatic write_ctrl(input logic [31:0] cmd);
		i2c_bridge_pkg::ctrl_cmd_t c;
		logic [31:0]               d;
		c = cmd;
		bus_access(1'b1, i2c_bridge_pkg::reg_ofs_ctrl, cmd, d);
		if (c.soft_rst) begin
			tx_q.delete();
			rx_q.delete();
			m_wstop   = 1'b0;
			m_rstop   = 1'b0;
			m_rerr    = 1'b0;
			m_rx_mask = 1'b1;
		end else begin
			if (c.tx_rst)
				tx_q.delete();
			if (c.rx_rst)
				rx_q.delete();
			if (c.clr_wstop)
				m_wstop = 1'b0;
			if (c.clr_rstop)
				m_rstop = 1'b0;
			if (c.clr_rerr)
				m_rerr = 1'b0;
			if (c.mask_rx)
				m_rx_mask = 1'b1;
			else if (c.unmask_rx)
				m_rx_mask = 1'b0;
		end
	endtask

	task automatic load_tx();
		logic [31:0] w;
		logic [31:0] d;
		w = $urandom();
		bus_access(1'b1, i2c_bridge_pkg::reg_ofs_tx, w, d);
		tx_q.push_back(w);
	endtask

	task automatic read_rx(input string name);
		logic [31:0] d;
		bus_access(1'b0, i2c_bridge_pkg::reg_ofs_rx, 32'h0, d);
		if (rx_q.size() != 0)
			check(name, rx_q.pop_front(), d);
	endtask

	// one bit is 8 clocks low then 8 clocks high
	task automatic send_bit(input logic b);
		wait_clks(4);
		sda_drv_low = ~b;
		wait_clks(4);
		scl_pin = 1'b1;
		wait_clks(8);
		scl_pin = 1'b0;
	endtask

	task automatic recv_bit(output logic b);
		wait_clks(4);
		sda_drv_low = 1'b0;
		wait_clks(4);
		scl_pin = 1'b1;
		wait_clks(4);
		b = sda_pin; // middle of the high phase
		wait_clks(4);
		scl_pin = 1'b0;
	endtask

	task automatic start_cond();
		sda_drv_low = 1'b0;
		scl_pin     = 1'b1;
		wait_clks(8);
		sda_drv_low = 1'b1; // sda falls while scl high
		wait_clks(8);
		scl_pin = 1'b0;
	endtask

	task automatic stop_cond();
		wait_clks(4);
		sda_drv_low = 1'b1;
		wait_clks(4);
		scl_pin = 1'b1;
		wait_clks(8);
		sda_drv_low = 1'b0; // sda rises while scl high
		wait_clks(16); // let the event reach the status bits
	endtask

	task automatic send_byte(input logic [7:0] b, output logic ack);
		logic nack;
		for (int i = 7; i >= 0; i--)
			send_bit(b[i]);
		recv_bit(nack);
		ack = ~nack;
	endtask

	task automatic recv_byte(output logic [7:0] b, input logic ack);
		for (int i = 7; i >= 0; i--)
			recv_bit(b[i]);
		send_bit(~ack);
	endtask

	task automatic i2c_write(input logic [6:0] addr, input int n_words, input string name);
		logic        exp_ack;
		logic        ack;
		logic        data_ack;
		logic [31:0] w;
		exp_ack = exp_addr_ack(addr, 1'b0);
		start_cond();
		send_byte({addr, 1'b0}, ack);
		check({name, " address ack"}, {31'b0, exp_ack}, {31'b0, ack});
		if (ack) begin
			for (int i = 0; i < n_words; i++) begin
				w = $urandom();
				for (int k = 3; k >= 0; k--) begin
					send_byte(w[k*8 +: 8], data_ack); // msb first
					check({name, " data ack"}, 32'd1, {31'b0, data_ack});
				end
				rx_q.push_back(w);
			end
		end
		if (exp_ack)
			m_wstop = 1'b1;
		stop_cond();
	endtask

	task automatic i2c_read(input logic [6:0] addr, input int n_words, input string name);
		logic        exp_ack;
		logic        ack;
		logic [7:0]  b;
		logic [31:0] w;
		exp_ack = exp_addr_ack(addr, 1'b1);
		start_cond();
		send_byte({addr, 1'b1}, ack);
		check({name, " address ack"}, {31'b0, exp_ack}, {31'b0, ack});
		if (ack) begin
			for (int i = 0; i < n_words; i++) begin
				w = '0;
				for (int k = 3; k >= 0; k--) begin
					recv_byte(b, !(i == n_words - 1 && k == 0)); // nack the last byte
					w = {w[23:0], b};
				end
				if (tx_q.size() != 0) begin
					check({name, " word"}, tx_q.pop_front(), w);
				end else begin
					errors++;
					$display("%s returned a word with nothing loaded to send", name);
				end
			end
		end
		if (exp_ack)
			m_rstop = 1'b1;
		else if (addr == m_dev_addr)
			m_rerr = 1'b1;
		stop_cond();
	endtask

	task automatic begin_test(input string name);
		test_name     = name;
		test_err_base = errors;
	endtask

	task automatic end_test();
		tests++;
		if (errors == test_err_base) begin
			$display("test %0d %s: ok", tests, test_name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d errors", tests, test_name, errors - test_err_base);
		end
	endtask

	initial begin
		#(watchdog_clks * clk_period);
		$display("watchdog expired, the tests did not finish in time");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		logic [31:0] d;
		int unsigned seed;
		RST_I        = 1'b1;
		bus_req      = '0;
		scl_pin      = 1'b1;
		sda_drv_low  = 1'b0;
		m_dev_addr   = 7'h0;
		m_wstop      = 1'b0;
		m_rstop      = 1'b0;
		m_rerr       = 1'b0;
		m_rx_mask    = 1'b1;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		failed_tests = 0;
		seed         = 32'hd73c_f95f;
		void'($urandom(seed));
		repeat (4) @(negedge CLK_I);
		RST_I = 1'b0;
		@(negedge CLK_I);

		begin_test("reset and registers");
		check("ack after reset", 32'd0, {31'b0, bus_ack});
		check("sda after reset", 32'd1, {31'b0, sda_pin});
		check("int after reset", 32'd0, {31'b0, int_i2c});
		check_status("reset status");
		bus_access(1'b1, i2c_bridge_pkg::reg_ofs_addr, {25'b0, own_addr}, d);
		m_dev_addr = own_addr;
		bus_access(1'b0, i2c_bridge_pkg::reg_ofs_addr, 32'h0, d);
		check("address readback", {25'b0, own_addr}, d);
		bus_access(1'b0, 6'h10, 32'h0, d);
		check("undefined offset", 32'hdeaddead, d);
		end_test();

		begin_test("master write");
		i2c_write(own_addr, 3, "write 3 words");
		check_status("status after write");
		check("int while masked", {31'b0, exp_int()}, {31'b0, int_i2c});
		write_ctrl(cmd_unmask_rx);
		check("int after unmask", {31'b0, exp_int()}, {31'b0, int_i2c});
		repeat (3)
			read_rx("rx word");
		check("int when drained", {31'b0, exp_int()}, {31'b0, int_i2c});
		write_ctrl(cmd_mask_rx | cmd_clr_wstop);
		check_status("status after readback");
		end_test();

		begin_test("foreign address");
		i2c_write(other_addr, 3, "foreign write");
		check_status("status after foreign write");
		end_test();

		begin_test("master read");
		repeat (3)
			load_tx();
		check_status("status with tx loaded");
		i2c_read(own_addr, 3, "read 3 words");
		check_status("status after read");
		end_test();

		begin_test("read refused");
		load_tx();
		i2c_read(own_addr, 1, "short read");
		check_status("status after refused read");
		write_ctrl(cmd_clr_rerr);
		check_status("status after clr_rerr");
		end_test();

		begin_test("write refusal and soft resets");
		i2c_write(own_addr, 8, "fill 8 words");
		i2c_write(own_addr, 7, "fill 7 words");
		i2c_write(own_addr, 1, "write at 15");
		check_status("status at 15 words");
		load_tx();
		write_ctrl(cmd_tx_rst);
		check_status("status after tx_rst");
		load_tx();
		write_ctrl(cmd_rx_rst);
		check_status("status after rx_rst");
		i2c_write(own_addr, 1, "write after rx_rst");
		i2c_read(own_addr, 1, "read below packet");
		write_ctrl(cmd_unmask_rx);
		check_status("status before soft_rst");
		write_ctrl(cmd_soft_rst);
		check_status("status after soft_rst");
		check("int after soft_rst", {31'b0, exp_int()}, {31'b0, int_i2c});
		end_test();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: i2c_bridge.f
source/i2c_bridge_pkg.sv
source/i2c_fifo.sv
source/i2c_phy.sv
source/i2c_regs.sv
source/i2c_bridge.sv
verification/i2c_bridge_tb.sv
